//--- verilog/sd_reader_pkg.sv
`default_nettype none

package sd_reader_pkg;

    // sdclk half periods, in clk cycles
    localparam logic [15:0] slow_div = 16'd4;   // identification, below 400 kHz
    localparam logic [15:0] fast_div = 16'd1;   // transfer mode

    // timeouts, in sdclk cycles
    localparam logic [7:0] cmd_timeout = 8'd100;  // wait for response start bit
    localparam logic [7:0] dat_timeout = 8'd200;  // wait for DAT0 start bit

    localparam int unsigned sector_bytes = 512;

    typedef enum logic [1:0] {
        unknown,
        sd_v1,
        sd_v2,
        sd_hc     // block addressed
    } card_type_t;

    // argument field of a 48-bit response, read according to the command sent
    typedef union packed {
        struct packed {
            logic        pwr_up;    // set once the card has left busy
            logic        ccs;       // capacity status
            logic [29:0] ocr;
        } r3_ocr;
        struct packed {
            logic [15:0] rca;
            logic [15:0] status;
        } r6_rca;
        struct packed {
            logic [19:0] reserved;
            logic [3:0]  voltage;
            logic [7:0]  pattern;   // echo of the CMD8 check pattern
        } r7_if;
    } sd_resp_u;

endpackage

`default_nettype wire

//--- verilog/sd_cmd_if.sv
`default_nettype none

interface sd_cmd_if;
    import sd_reader_pkg::*;

    logic        start;       // one cycle, only while busy is low
    logic [5:0]  index;
    logic [31:0] arg;
    logic        fast;
    logic        long_resp;   // 136-bit R2
    logic        no_resp;
    logic [15:0] precycles;   // idle clocks ahead of the command
    logic        busy;
    logic        done;
    logic        timeout;
    logic        bad_resp;
    sd_resp_u    resp;

    modport seq (output start, index, arg, fast, long_resp, no_resp, precycles,
                 input  busy, done, timeout, bad_resp, resp);
    modport ctrl (input  start, index, arg, fast, long_resp, no_resp, precycles,
                  output busy, done, timeout, bad_resp, resp);

endinterface

`default_nettype wire

//--- verilog/sd_cmd_ctrl.sv
`default_nettype none

module sd_cmd_ctrl (
    input  wire    clk,
    input  wire    rst_n,
    sd_cmd_if.ctrl cmd,
    output logic   sdclk,
    output logic   sd_cmd_out,
    output logic   sd_cmd_oe,
    input  wire    sd_cmd_in
);
    import sd_reader_pkg::*;

    enum logic [2:0] {c_idle, c_pre, c_send, c_wait, c_recv} state;

    logic        fast_q;
    logic        long_q;
    logic        no_resp_q;
    logic [5:0]  index_q;
    logic [15:0] div_cnt;
    logic [15:0] half;
    logic [15:0] pre_cnt;
    logic [47:0] tx_sh;
    logic [47:0] rx_sh;
    logic [47:0] rx_next;
    logic [7:0]  bit_cnt;
    logic [7:0]  tcnt;
    logic        tick;
    logic        rise;
    logic        fall;
    logic        last_bit;
    logic        skip_crc;

    // x^7 + x^3 + 1 over start, direction, index and argument
    function automatic logic [6:0] crc7(input logic [39:0] data);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb   = data[i] ^ c[6];
            c    = {c[5:0], fb};
            c[3] = c[3] ^ fb;
        end
        return c;
    endfunction

    assign half     = fast_q ? fast_div : slow_div;
    assign tick     = div_cnt >= half - 16'd1;   // >= so a divider change never stalls
    assign rise     = tick && !sdclk;
    assign fall     = tick && sdclk;
    assign rx_next  = {rx_sh[46:0], sd_cmd_in};
    assign last_bit = bit_cnt == (long_q ? 8'd135 : 8'd47);
    assign skip_crc = long_q || index_q == 6'd41;   // R2 and R3 carry no valid CRC7
    assign cmd.busy = state != c_idle;

    // free running, also between commands for the data receiver
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            sdclk   <= 1'b0;
        end else if (tick) begin
            div_cnt <= '0;
            sdclk   <= !sdclk;
        end else begin
            div_cnt <= div_cnt + 16'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= c_idle;
            fast_q       <= 1'b0;
            long_q       <= 1'b0;
            no_resp_q    <= 1'b0;
            index_q      <= '0;
            pre_cnt      <= '0;
            bit_cnt      <= '0;
            tcnt         <= '0;
            sd_cmd_oe    <= 1'b0;
            sd_cmd_out   <= 1'b1;
            cmd.done     <= 1'b0;
            cmd.timeout  <= 1'b0;
            cmd.bad_resp <= 1'b0;
        end else begin
            cmd.done <= 1'b0;
            case (state)
                c_idle: if (cmd.start) begin
                    fast_q       <= cmd.fast;
                    long_q       <= cmd.long_resp;
                    no_resp_q    <= cmd.no_resp;
                    index_q      <= cmd.index;
                    pre_cnt      <= cmd.precycles;
                    cmd.timeout  <= 1'b0;
                    cmd.bad_resp <= 1'b0;
                    state        <= c_pre;
                end
                c_pre: if (fall) begin
                    if (pre_cnt == 16'd0) begin
                        sd_cmd_oe  <= 1'b1;
                        sd_cmd_out <= tx_sh[47];   // start bit
                        bit_cnt    <= 8'd1;
                        state      <= c_send;
                    end else begin
                        pre_cnt <= pre_cnt - 16'd1;
                    end
                end
                c_send: if (fall) begin
                    if (bit_cnt == 8'd48) begin
                        sd_cmd_oe  <= 1'b0;
                        sd_cmd_out <= 1'b1;
                        tcnt       <= '0;
                        if (no_resp_q) begin
                            cmd.done <= 1'b1;
                            state    <= c_idle;
                        end else begin
                            state <= c_wait;
                        end
                    end else begin
                        sd_cmd_out <= tx_sh[46];   // tx_sh shifts on this same edge
                        bit_cnt    <= bit_cnt + 8'd1;
                    end
                end
                c_wait: if (rise) begin
                    if (!sd_cmd_in) begin
                        bit_cnt <= 8'd1;
                        state   <= c_recv;
                    end else if (tcnt == cmd_timeout - 8'd1) begin
                        cmd.timeout <= 1'b1;
                        cmd.done    <= 1'b1;
                        state       <= c_idle;
                    end else begin
                        tcnt <= tcnt + 8'd1;
                    end
                end
                c_recv: if (rise) begin
                    if (last_bit) begin
                        cmd.bad_resp <= !rx_next[0] ||
                                        (!skip_crc && crc7(rx_next[47:8]) != rx_next[7:1]);
                        cmd.done     <= 1'b1;
                        state        <= c_idle;
                    end else begin
                        bit_cnt <= bit_cnt + 8'd1;
                    end
                end
                default: state <= c_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == c_idle && cmd.start) begin
            tx_sh <= {2'b01, cmd.index, cmd.arg, crc7({2'b01, cmd.index, cmd.arg}), 1'b1};
        end else if (fall && state == c_send) begin
            tx_sh <= {tx_sh[46:0], 1'b1};
        end
        if (rise && (state == c_wait || state == c_recv)) begin
            rx_sh <= rx_next;   // idle ones shift through until the start bit
        end
        if (rise && state == c_recv && last_bit) begin
            cmd.resp <= rx_next[39:8];
        end
    end

endmodule

`default_nettype wire

//--- verilog/sd_dat_rx.sv
`default_nettype none

module sd_dat_rx (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        sdclk,
    input  wire        sd_dat0,
    input  wire        active,
    output logic       done,
    output logic       timeout,
    output logic       out_valid,
    output logic [8:0] out_addr,
    output logic [7:0] out_byte
);
    import sd_reader_pkg::*;

    enum logic [1:0] {r_wait, r_data, r_tail, r_stop} state;

    logic        sdclk_q;
    logic        rise;
    logic        byte_end;
    logic [11:0] bit_cnt;
    logic [7:0]  wait_cnt;
    logic [6:0]  byte_sh;

    assign rise     = sdclk && !sdclk_q;
    assign byte_end = active && rise && state == r_data && bit_cnt[2:0] == 3'd7;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sdclk_q   <= 1'b0;
            state     <= r_wait;
            bit_cnt   <= '0;
            wait_cnt  <= '0;
            done      <= 1'b0;
            timeout   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            sdclk_q   <= sdclk;
            done      <= 1'b0;
            timeout   <= 1'b0;
            out_valid <= byte_end;
            if (!active) begin
                state    <= r_wait;
                bit_cnt  <= '0;
                wait_cnt <= '0;
            end else if (rise) begin
                case (state)
                    r_wait: if (!sd_dat0) begin   // start bit
                        bit_cnt <= '0;
                        state   <= r_data;
                    end else if (wait_cnt == dat_timeout - 8'd1) begin
                        timeout <= 1'b1;
                        state   <= r_stop;
                    end else begin
                        wait_cnt <= wait_cnt + 8'd1;
                    end
                    r_data: if (bit_cnt == 12'(sector_bytes * 8 - 1)) begin
                        bit_cnt <= '0;
                        state   <= r_tail;
                    end else begin
                        bit_cnt <= bit_cnt + 12'd1;
                    end
                    // crc16 and end bit, counted only
                    r_tail: if (bit_cnt == 12'd16) begin
                        done  <= 1'b1;
                        state <= r_stop;
                    end else begin
                        bit_cnt <= bit_cnt + 12'd1;
                    end
                    default: ;   // r_stop holds until active drops
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rise && state == r_data) begin
            byte_sh <= {byte_sh[5:0], sd_dat0};   // msb first
        end
        if (byte_end) begin
            out_byte <= {byte_sh, sd_dat0};
            out_addr <= bit_cnt[11:3];
        end
    end

endmodule

`default_nettype wire

//--- verilog/sd_card_seq.sv
`default_nettype none

module sd_card_seq (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       rd_valid,
    input  wire  [31:0]               rd_sector,
    output logic                      rd_ready,
    output logic                      rd_done,
    output sd_reader_pkg::card_type_t card_type,
    output logic                      card_ready,
    sd_cmd_if.seq                     cmd,
    output logic                      dat_active,
    input  wire                       dat_done,
    input  wire                       dat_timeout
);
    import sd_reader_pkg::*;

    enum logic [3:0] {
        s_cmd0, s_cmd8, s_cmd55, s_acmd41, s_cmd2, s_cmd3, s_cmd7, s_cmd16,
        s_idle, s_rd_cmd, s_rd_data
    } state;

    logic        waiting;   // command issued, done not yet seen
    logic        cmd_ok;
    logic [15:0] rca;
    logic [31:0] rd_addr;

    assign cmd_ok     = !cmd.timeout && !cmd.bad_resp;
    assign rd_ready   = state == s_idle;
    assign card_ready = state == s_idle || state == s_rd_cmd || state == s_rd_data;
    assign dat_active = state == s_rd_data;
    assign cmd.start  = !waiting && !cmd.busy && state != s_idle && state != s_rd_data;

    always_comb begin
        cmd.index     = 6'd0;
        cmd.arg       = '0;
        cmd.fast      = 1'b0;
        cmd.long_resp = 1'b0;
        cmd.no_resp   = 1'b0;
        cmd.precycles = 16'd8;
        case (state)
            s_cmd0: begin
                cmd.no_resp   = 1'b1;
                cmd.precycles = 16'd80;   // power-up clocks
            end
            s_cmd8: begin
                cmd.index = 6'd8;
                cmd.arg   = 32'h0000_01AA;   // 2.7-3.6 V, pattern aa
            end
            s_cmd55: cmd.index = 6'd55;
            s_acmd41: begin
                cmd.index = 6'd41;
                cmd.arg   = (card_type == sd_v1) ? 32'h0010_0000 : 32'h4010_0000;   // hcs
            end
            s_cmd2: begin
                cmd.index     = 6'd2;
                cmd.long_resp = 1'b1;
            end
            s_cmd3: cmd.index = 6'd3;
            s_cmd7: begin
                cmd.index = 6'd7;
                cmd.arg   = {rca, 16'h0000};
            end
            s_cmd16: begin
                cmd.index = 6'd16;
                cmd.arg   = 32'(sector_bytes);
                cmd.fast  = 1'b1;
            end
            s_rd_cmd: begin
                cmd.index     = 6'd17;
                cmd.arg       = rd_addr;
                cmd.fast      = 1'b1;
                cmd.precycles = 16'd16;
            end
            default: ;
        endcase
    end

    // a failed command stays in its state and is issued again
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= s_cmd0;
            waiting   <= 1'b0;
            card_type <= unknown;
            rca       <= '0;
            rd_addr   <= '0;
            rd_done   <= 1'b0;
        end else begin
            rd_done <= 1'b0;
            if (cmd.start) waiting <= 1'b1;
            if (cmd.done) begin
                waiting <= 1'b0;
                case (state)
                    s_cmd0: state <= s_cmd8;
                    s_cmd8: if (cmd.timeout) begin
                        card_type <= sd_v1;   // no reply to CMD8
                        state     <= s_cmd55;
                    end else if (cmd_ok && cmd.resp.r7_if.voltage == 4'h1 &&
                                 cmd.resp.r7_if.pattern == 8'hAA) begin
                        state <= s_cmd55;
                    end
                    s_cmd55: if (cmd_ok) state <= s_acmd41;
                    s_acmd41: if (cmd_ok && cmd.resp.r3_ocr.pwr_up) begin
                        if (card_type != sd_v1) begin
                            card_type <= cmd.resp.r3_ocr.ccs ? sd_hc : sd_v2;
                        end
                        state <= s_cmd2;
                    end else begin
                        state <= s_cmd55;   // still busy, poll again
                    end
                    s_cmd2: if (cmd_ok) state <= s_cmd3;
                    s_cmd3: if (cmd_ok) begin
                        rca   <= cmd.resp.r6_rca.rca;
                        state <= s_cmd7;
                    end
                    s_cmd7: if (cmd_ok) state <= s_cmd16;
                    s_cmd16: if (cmd_ok) state <= s_idle;
                    s_rd_cmd: if (cmd_ok) state <= s_rd_data;
                    default: ;
                endcase
            end
            case (state)
                s_idle: if (rd_valid) begin
                    rd_addr <= (card_type == sd_hc) ? rd_sector
                                                    : rd_sector * 32'(sector_bytes);
                    state   <= s_rd_cmd;
                end
                s_rd_data: if (dat_done) begin
                    rd_done <= 1'b1;
                    state   <= s_idle;
                end else if (dat_timeout) begin
                    state <= s_rd_cmd;   // no start bit, read again
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/sd_reader.sv
`default_nettype none

module sd_reader (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       rd_valid,
    output logic                      rd_ready,
    input  wire  [31:0]               rd_sector,
    output logic                      rd_done,
    output logic                      out_valid,
    output logic [8:0]                out_addr,
    output logic [7:0]                out_byte,
    output sd_reader_pkg::card_type_t card_type,
    output logic                      card_ready,
    output logic                      sdclk,
    output logic                      sd_cmd_out,
    output logic                      sd_cmd_oe,
    input  wire                       sd_cmd_in,
    input  wire                       sd_dat0
);

    logic dat_active;
    logic dat_done;
    logic dat_timeout;

    sd_cmd_if cmd_bus ();

    sd_cmd_ctrl u_cmd_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd_bus.ctrl),
        .sdclk      (sdclk),
        .sd_cmd_out (sd_cmd_out),
        .sd_cmd_oe  (sd_cmd_oe),
        .sd_cmd_in  (sd_cmd_in)
    );

    sd_dat_rx u_dat_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .sdclk     (sdclk),
        .sd_dat0   (sd_dat0),
        .active    (dat_active),
        .done      (dat_done),
        .timeout   (dat_timeout),
        .out_valid (out_valid),
        .out_addr  (out_addr),
        .out_byte  (out_byte)
    );

    sd_card_seq u_card_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_valid    (rd_valid),
        .rd_sector   (rd_sector),
        .rd_ready    (rd_ready),
        .rd_done     (rd_done),
        .card_type   (card_type),
        .card_ready  (card_ready),
        .cmd         (cmd_bus.seq),
        .dat_active  (dat_active),
        .dat_done    (dat_done),
        .dat_timeout (dat_timeout)
    );

endmodule

`default_nettype wire

//--- test/sd_reader_properties.sv
`default_nettype none

module sd_reader_properties (
    input wire clk,
    input wire rst_n,
    input wire rd_valid,
    input wire rd_ready,
    input wire rd_done,
    input wire out_valid,
    input wire sd_cmd_oe
);
    timeunit 1ns;
    timeprecision 1ps;

    logic in_read;   // from acceptance until rd_done

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_read <= 1'b0;
        end else if (rd_valid && rd_ready) begin
            in_read <= 1'b1;
        end else if (rd_done) begin
            in_read <= 1'b0;
        end
    end

    // bytes only while a read runs
    a_out_in_read: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> in_read)
        else $error("out_valid outside a read");

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rd_done |=> !rd_done)
        else $error("rd_done wider than one cycle");

    a_oe_reset: assert property (@(posedge clk) !rst_n |-> !sd_cmd_oe)
        else $error("sd_cmd_oe high in reset");

    a_ready_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_ready && out_valid))
        else $error("rd_ready and out_valid both high");

endmodule

`default_nettype wire

//--- test/sd_card_model.sv
`default_nettype none

module sd_card_model (
    input  wire                             sdclk,
    input  wire                             cmd_out,
    input  wire                             cmd_oe,
    output logic                            cmd_in,
    output logic                            dat0,
    input  wire  sd_reader_pkg::card_type_t kind,
    input  wire  [1:0]                      fault,      // 1 bad crc7, 2 no data start
    output int                              cmd17_count,
    output int                              protocol_errors
);
    timeunit 1ns;
    timeprecision 1ps;
    import sd_reader_pkg::*;

    logic [47:0] c;
    int          polls;
    logic        pending;   // fault not yet injected since CMD0

    function automatic logic [6:0] crc7_of(input logic [39:0] d);
        logic [6:0] r;
        logic       inv;
        r = '0;
        for (int i = 39; i >= 0; i--) begin
            inv = d[i] ^ r[6];
            r   = {r[5:0], 1'b0};
            if (inv) r = r ^ 7'h09;
        end
        return r;
    endfunction

    // response bits change after falling edges
    task automatic drive_cmd(input logic [135:0] bits, input int n);
        repeat (2) @(negedge sdclk);
        for (int i = n - 1; i >= 0; i--) begin
            @(negedge sdclk);
            cmd_in = bits[i];
        end
        @(negedge sdclk);
        cmd_in = 1'b1;
    endtask

    task automatic send_r1(input logic [5:0] idx, input logic [31:0] arg, input logic flip);
        logic [6:0] crc;
        crc = crc7_of({2'b00, idx, arg}) ^ {6'b0, flip};
        drive_cmd(136'({2'b00, idx, arg, crc, 1'b1}), 48);
    endtask

    task automatic send_data(input logic [31:0] arg);
        logic [7:0] b;
        repeat (8) @(negedge sdclk);
        dat0 = 1'b0;   // start bit
        for (int i = 0; i < 512; i++) begin
            b = arg[7:0] + arg[15:8] + 8'(i);
            for (int j = 7; j >= 0; j--) begin
                @(negedge sdclk);
                dat0 = b[j];
            end
        end
        repeat (16) begin
            @(negedge sdclk);
            dat0 = 1'b0;   // crc16 never checked
        end
        @(negedge sdclk);
        dat0 = 1'b1;
    endtask

    initial begin
        cmd_in          = 1'b1;
        dat0            = 1'b1;
        cmd17_count     = 0;
        protocol_errors = 0;
        polls           = 0;
        pending         = 1'b0;
        forever begin
            do @(posedge sdclk); while (!(cmd_oe && !cmd_out));
            c[47] = 1'b0;
            for (int i = 46; i >= 0; i--) begin
                @(posedge sdclk);
                c[i] = cmd_out;
            end
            if (crc7_of(c[47:8]) != c[7:1] || !c[0]) protocol_errors++;
            case (c[45:40])
                6'd0: begin
                    polls   = 0;
                    pending = fault != 2'd0;
                end
                6'd8: if (kind != sd_v1) send_r1(6'd8, {20'h0, 4'h1, c[15:8]}, 1'b0);
                6'd55: send_r1(6'd55, 32'h0000_0120, 1'b0);
                6'd41: begin   // R3, first poll busy
                    drive_cmd(136'({2'b00, 6'h3f, polls != 0, kind == sd_hc,
                                    30'h00ff_8000, 7'h7f, 1'b1}), 48);
                    polls++;
                end
                6'd2: drive_cmd({2'b00, 6'h3f, 120'h1234_5678_9abc_def0_1122_3344_5566_77,
                                 7'h55, 1'b1}, 136);
                6'd3: send_r1(6'd3, 32'h1234_0500, 1'b0);
                6'd7: begin
                    if (c[39:24] != 16'h1234) protocol_errors++;   // wrong rca
                    send_r1(6'd7, 32'h0000_0700, 1'b0);
                end
                6'd16: send_r1(6'd16, 32'h0000_0900, 1'b0);
                6'd17: begin
                    cmd17_count++;
                    if (pending && fault == 2'd1) begin
                        send_r1(6'd17, 32'h0000_0900, 1'b1);
                    end else begin
                        send_r1(6'd17, 32'h0000_0900, 1'b0);
                        if (!(pending && fault == 2'd2)) send_data(c[39:8]);
                    end
                    pending = 1'b0;
                end
                default: protocol_errors++;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- test/tb_sd_reader.sv
`default_nettype none

module tb_sd_reader;
    timeunit 1ns;
    timeprecision 1ps;
    import sd_reader_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        rd_valid;
    logic [31:0] rd_sector;
    logic        rd_ready;
    logic        rd_done;
    logic        out_valid;
    logic [8:0]  out_addr;
    logic [7:0]  out_byte;
    card_type_t  card_type;
    logic        card_ready;
    logic        sdclk;
    logic        sd_cmd_out;
    logic        sd_cmd_oe;
    logic        sd_cmd_in;
    logic        sd_dat0;
    card_type_t  model_kind;
    logic [1:0]  model_fault;
    int          cmd17_count;
    int          protocol_errors;

    logic [63:0] stim [0:63];
    int          nlines;
    int          limit = 0;
    int          cycles = 0;
    int          seed;
    logic        fault_pending;
    card_type_t  cur_type;

    always #50 clk = ~clk;

    sd_reader dut0 (.*);

    sd_card_model model0 (
        .sdclk (sdclk), .cmd_out (sd_cmd_out), .cmd_oe (sd_cmd_oe), .cmd_in (sd_cmd_in),
        .dat0 (sd_dat0), .kind (model_kind), .fault (model_fault),
        .cmd17_count (cmd17_count), .protocol_errors (protocol_errors)
    );

    bind sd_reader sd_reader_properties props0 (
        .clk (clk), .rst_n (rst_n), .rd_valid (rd_valid), .rd_ready (rd_ready),
        .rd_done (rd_done), .out_valid (out_valid), .sd_cmd_oe (sd_cmd_oe)
    );

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic reset_card(input card_type_t kind, input logic [1:0] fault,
                              input card_type_t exp);
        model_kind    = kind;
        model_fault   = fault;
        fault_pending = fault != 2'd0;
        cur_type      = exp;
        rst_n         = 1'b0;
        repeat (2) next_cycle();
        check(32'(card_ready), 32'd0, "card_ready in reset");
        check(32'(rd_ready), 32'd0, "rd_ready in reset");
        check(32'(card_type), 32'(unknown), "card_type in reset");
        rst_n = 1'b1;
        while (!card_ready) next_cycle();
        check(32'(card_type), 32'(exp), "card_type");
    endtask

    // rd_valid stays high until rd_done so a second take would show
    task automatic read_sector(input logic [31:0] sector);
        logic [31:0] exp_arg;
        logic [7:0]  exp_byte;
        int          count;
        int          cmd17_before;
        exp_arg      = (cur_type == sd_hc) ? sector : sector << 9;
        count        = 0;
        cmd17_before = cmd17_count;
        rd_sector    = sector;
        rd_valid     = 1'b1;
        while (!rd_ready) next_cycle();
        next_cycle();   // accepted on this edge
        while (!rd_done) begin
            check(32'(rd_ready), 32'd0, "rd_ready during read");
            if (out_valid) begin
                exp_byte = exp_arg[7:0] + exp_arg[15:8] + 8'(count);
                check(32'(out_addr), count, "out_addr");
                check(32'(out_byte), 32'(exp_byte), "out_byte");
                count++;
            end
            next_cycle();
        end
        rd_valid = 1'b0;
        check(count, 32'd512, "byte count at rd_done");
        check(cmd17_count - cmd17_before, fault_pending ? 32'd2 : 32'd1, "CMD17 count");
        check(protocol_errors, 32'd0, "model protocol errors");
        fault_pending = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d clock cycles", limit);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped by cycle limit");
        end
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        rd_valid      = 1'b0;
        rd_sector     = '0;
        model_kind    = sd_v2;
        model_fault   = 2'd0;
        fault_pending = 1'b0;
        cur_type      = unknown;
        seed          = 77;
        for (int i = 0; i < 64; i++) stim[i] = '0;
        $readmemh("test/sd_reader_stimulus.txt", stim);
        nlines = 0;
        while (nlines < 64 && stim[nlines][63:56] != 8'd0) nlines++;
        if (nlines == 0) begin
            $display("no stimulus lines found in the stimulus file");
            $display("Simulation finished: FAIL");
            $fatal(1, "nothing to run");
        end
        limit = nlines * 12000 * 2;   // worst init or read with retries, doubled
        for (int i = 0; i < nlines; i++) begin
            case (stim[i][63:56])
                8'd1: reset_card(card_type_t'(stim[i][49:48]), stim[i][41:40],
                                 card_type_t'(stim[i][33:32]));
                8'd2: read_sector(stim[i][31:0]);
                8'd3: read_sector($random(seed) & 32'h003f_ffff);
                default: check(32'(stim[i][63:56]), 32'd1, "stimulus op code");
            endcase
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/sd_reader_stimulus.txt
// op_kind_fault_exp_sector, op 01 reset with card kind, 02 read sector, 03 read a random sector
// kind and exp 1 v1, 2 v2, 3 high capacity; fault 1 bad CMD17 crc7, 2 no data start bit
01_01_00_01_00000000
02_00_00_00_00000003
02_00_00_00_00000081
01_02_01_02_00000000
02_00_00_00_00000010
03_00_00_00_00000000
01_03_02_03_00000000
02_00_00_00_00012345
02_00_00_00_00000007
03_00_00_00_00000000

//--- sd_reader.f
verilog/sd_reader_pkg.sv
verilog/sd_cmd_if.sv
verilog/sd_cmd_ctrl.sv
verilog/sd_dat_rx.sv
verilog/sd_card_seq.sv
verilog/sd_reader.sv
test/sd_reader_properties.sv
test/sd_card_model.sv
test/tb_sd_reader.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and judge the result from the log

rm -f sim.log
verilator --binary --timing --assert --top-module tb_sd_reader \
    -f sd_reader.f -o sim_tb_sd_reader \
    && ./obj_dir/sim_tb_sd_reader > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }
